// File: hw/nbbpu_macros.svh
/*
 * Core-wide constants. The instruction encoding assumes a 16-bit word and
 * 16 registers; changing these alone does not re-encode the fields.
 */
`ifndef NBBPU_MACROS_SVH
`define NBBPU_MACROS_SVH

// Data, address and instruction width
`define NBBPU_WIDTH 16

// Register count, index is 4 bits
`define NBBPU_REGS 16

`define NBBPU_RESET_PC 16'h0000   // First fetch address

// Store that marks a program as finished successfully
`define NBBPU_PASS_ADDR 16'hFFF0
`define NBBPU_PASS_DATA 16'd42

`endif

// File: hw/nbbpu_pkg.sv
/*
 * Shared types for the core. Opcode values are fixed by the instruction
 * encoding; the controller relies on ALU ops through LOAD being contiguous.
 */
package nbbpu_pkg;

    // Four cycles per instruction, visited in order
    typedef enum logic [1:0] {
        FETCH   = 2'd0,     // ROM word at pc is valid
        DECODE  = 2'd1,
        EXECUTE = 2'd2,     // RAM read for LOAD
        STORE   = 2'd3      // Register, RAM and PC update on exit
    } state_t;

    typedef enum logic [3:0] {
        OP_ADD    = 4'd0,
        OP_SUB    = 4'd1,
        OP_AND    = 4'd2,
        OP_OR     = 4'd3,
        OP_XOR    = 4'd4,
        OP_SHL    = 4'd5,
        OP_SHR    = 4'd6,
        OP_SETL   = 4'd7,   // Low byte immediate, zero extended
        OP_SETH   = 4'd8,   // High byte immediate over low byte of reg z
        OP_LOAD   = 4'd9,
        OP_STORE  = 4'd10,
        OP_JUMP   = 4'd11,
        OP_BRANCH = 4'd12,  // Taken when Y is zero
        OP_CALL   = 4'd13,  // Link into reg z
        OP_NOP    = 4'd14,
        OP_NOP_15 = 4'd15   // Second NOP encoding
    } opcode_t;

endpackage

// File: hw/nbbpu_controller.sv
/*
 * Combinational decode of cycle state and opcode into control levels.
 * Memory enables are plain levels; the RAM samples write_enable on the
 * edge that leaves STORE.
 */
module nbbpu_controller
(
    input  nbbpu_pkg::state_t  state,
    input  nbbpu_pkg::opcode_t opcode,
    output logic               instruction_enable,
    output logic               read_enable,
    output logic               write_enable,
    output logic               reg_write,
    output logic               reg_set,
    output logic               jump_pc,
    output logic               branch_pc,
    output logic               store_pc
);

    logic produces_result;

    // ALU ops, SETL, SETH and LOAD occupy codes 0..9
    assign produces_result = (opcode <= nbbpu_pkg::OP_LOAD) ||
                             (opcode == nbbpu_pkg::OP_CALL);

    // ------------------------------------------------------------------------
    // Memory enables
    // ------------------------------------------------------------------------
    assign instruction_enable = (state == nbbpu_pkg::FETCH);
    assign read_enable        = (state == nbbpu_pkg::EXECUTE) &&
                                (opcode == nbbpu_pkg::OP_LOAD);
    assign write_enable       = (state == nbbpu_pkg::STORE) &&
                                (opcode == nbbpu_pkg::OP_STORE);

    // ------------------------------------------------------------------------
    // Register file and PC control
    // ------------------------------------------------------------------------
    assign reg_write = (state == nbbpu_pkg::STORE) && produces_result;

    // SETH reads its low byte from z, CALL writes its link to z
    assign reg_set = (opcode == nbbpu_pkg::OP_SETH) ||
                     (opcode == nbbpu_pkg::OP_CALL);

    assign jump_pc   = (opcode == nbbpu_pkg::OP_JUMP) ||
                       (opcode == nbbpu_pkg::OP_CALL);   // CALL jumps too
    assign branch_pc = (opcode == nbbpu_pkg::OP_BRANCH);
    assign store_pc  = (state == nbbpu_pkg::STORE);      // Every instruction

    // ------------------------------------------------------------------------
    // Checks, sampled whenever the cycle state moves on
    // ------------------------------------------------------------------------
    // Opcode must hold from FETCH until the instruction leaves STORE
    a_opcode_held : assert property (@(state)
        (state != nbbpu_pkg::FETCH) |-> $stable(opcode))
        else $error("Opcode changed in the middle of an instruction");

    a_store_follows_execute : assert property (@(state)
        (state == nbbpu_pkg::STORE) |-> ($past(state) == nbbpu_pkg::EXECUTE))
        else $error("STORE entered from state %0d", $past(state));

endmodule

// File: hw/nbbpu_regfile.sv
/*
 * Register file, two combinational read ports and one write port.
 * A read in the cycle of a write returns the old value.
 */
`include "nbbpu_macros.svh"

module nbbpu_regfile
(
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             write_enable,
    input  logic [$clog2(`NBBPU_REGS)-1:0]   write_index,
    input  logic [`NBBPU_WIDTH-1:0]          write_value,
    input  logic [$clog2(`NBBPU_REGS)-1:0]   read_index_a,
    input  logic [$clog2(`NBBPU_REGS)-1:0]   read_index_b,
    output logic [`NBBPU_WIDTH-1:0]          read_value_a,
    output logic [`NBBPU_WIDTH-1:0]          read_value_b
);

    logic [`NBBPU_WIDTH-1:0] regs [`NBBPU_REGS];

    // Write on the edge that leaves STORE
    always_ff @(posedge clock or posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < `NBBPU_REGS; i++)
                regs[i] <= '0;
        end
        else if (write_enable)
        begin
            regs[write_index] <= write_value;
        end
    end

    assign read_value_a = regs[read_index_a];   // X
    assign read_value_b = regs[read_index_b];   // Y

endmodule

// File: hw/nbbpu_alu.sv
/*
 * Result selection by opcode. For BRANCH the result is only a flag in
 * bit 0 (Y is zero); the core decides the PC from it. JUMP and NOP
 * produce zero.
 */
`include "nbbpu_macros.svh"

module nbbpu_alu
(
    input  logic [`NBBPU_WIDTH-1:0] x_value,
    input  logic [`NBBPU_WIDTH-1:0] y_value,
    input  logic [`NBBPU_WIDTH-1:0] instruction,
    input  logic [`NBBPU_WIDTH-1:0] read_data,
    input  logic [`NBBPU_WIDTH-1:0] pc,
    output logic [`NBBPU_WIDTH-1:0] result
);

    nbbpu_pkg::opcode_t opcode;
    logic [7:0]         immediate;
    logic [3:0]         shift;
    logic               y_zero;

    assign opcode    = nbbpu_pkg::opcode_t'(instruction[15:12]);
    assign immediate = instruction[11:4];   // Spans the x and y fields
    assign shift     = y_value[3:0];
    assign y_zero    = (y_value == '0);

    // ------------------------------------------------------------------------
    // Result mux
    // ------------------------------------------------------------------------
    always_comb
    begin
        case (opcode)
            nbbpu_pkg::OP_ADD:    result = x_value + y_value;
            nbbpu_pkg::OP_SUB:    result = x_value - y_value;
            nbbpu_pkg::OP_AND:    result = x_value & y_value;
            nbbpu_pkg::OP_OR:     result = x_value | y_value;
            nbbpu_pkg::OP_XOR:    result = x_value ^ y_value;
            nbbpu_pkg::OP_SHL:    result = x_value << shift;
            nbbpu_pkg::OP_SHR:    result = x_value >> shift;   // Logical
            nbbpu_pkg::OP_SETL:
                result = {{(`NBBPU_WIDTH-8){1'b0}}, immediate};
            nbbpu_pkg::OP_SETH:
                result = {immediate, x_value[7:0]};   // X read from reg z
            nbbpu_pkg::OP_LOAD:   result = read_data;
            nbbpu_pkg::OP_STORE:  result = y_value;   // Goes out as write_data
            nbbpu_pkg::OP_BRANCH:
                result = {{(`NBBPU_WIDTH-1){1'b0}}, y_zero};
            nbbpu_pkg::OP_CALL:   result = pc + 1'b1;   // Link address
            default:              result = '0;
        endcase
    end

endmodule

// File: hw/nbbpu_core.sv
/*
 * Non-pipelined 16-bit core, four cycles per instruction. ROM and RAM sit
 * outside and must answer combinationally. Register, RAM and PC updates
 * all land on the edge that leaves STORE, so pc moves once per instruction.
 */
`include "nbbpu_macros.svh"

module nbbpu_core
(
    input  logic                    clock,
    input  logic                    reset,
    input  logic [`NBBPU_WIDTH-1:0] instruction,    // ROM word at pc
    input  logic [`NBBPU_WIDTH-1:0] read_data,      // RAM word at address
    output logic                    instruction_enable,
    output logic                    read_enable,
    output logic                    write_enable,
    output logic [`NBBPU_WIDTH-1:0] address,
    output logic [`NBBPU_WIDTH-1:0] write_data,
    output logic [`NBBPU_WIDTH-1:0] pc
);

    nbbpu_pkg::state_t  state;
    nbbpu_pkg::state_t  next_state;
    nbbpu_pkg::opcode_t opcode;

    logic [3:0] x_field;
    logic [3:0] x_index;
    logic [3:0] y_index;
    logic [3:0] z_index;

    logic reg_write;
    logic reg_set;
    logic jump_pc;
    logic branch_pc;
    logic store_pc;
    logic take_x;

    logic [`NBBPU_WIDTH-1:0] x_value;
    logic [`NBBPU_WIDTH-1:0] y_value;
    logic [`NBBPU_WIDTH-1:0] z_value;
    logic [`NBBPU_WIDTH-1:0] next_pc;

    // Instruction fields
    assign opcode  = nbbpu_pkg::opcode_t'(instruction[15:12]);
    assign x_field = instruction[11:8];
    assign y_index = instruction[7:4];
    assign z_index = instruction[3:0];
    assign x_index = reg_set ? z_index : x_field;  // SETH and CALL use z as x

    assign address    = x_value;
    assign write_data = z_value;

    // ------------------------------------------------------------------------
    // Cycle state machine
    // ------------------------------------------------------------------------
    always_comb
    begin
        case (state)
            nbbpu_pkg::FETCH:   next_state = nbbpu_pkg::DECODE;
            nbbpu_pkg::DECODE:  next_state = nbbpu_pkg::EXECUTE;
            nbbpu_pkg::EXECUTE: next_state = nbbpu_pkg::STORE;
            default:            next_state = nbbpu_pkg::FETCH;
        endcase
    end

    always_ff @(posedge clock or posedge reset)
    begin
        if (reset)
            state <= nbbpu_pkg::FETCH;
        else
            state <= next_state;
    end

    // ------------------------------------------------------------------------
    // Program counter
    // ------------------------------------------------------------------------
    // Branch flag is bit 0 of the ALU result
    assign take_x  = jump_pc || (branch_pc && z_value[0]);
    assign next_pc = take_x ? x_value : pc + 1'b1;

    always_ff @(posedge clock or posedge reset)
    begin
        if (reset)
            pc <= `NBBPU_RESET_PC;
        else if (store_pc)
            pc <= next_pc;
    end

    a_pc_moves_in_store : assert property (@(posedge clock) disable iff (reset)
        !$stable(pc) |-> $past(state) == nbbpu_pkg::STORE)
        else $error("pc changed outside the STORE exit edge");

    // ------------------------------------------------------------------------
    // Instances
    // ------------------------------------------------------------------------
    nbbpu_controller u_controller (
        .state              (state),
        .opcode             (opcode),
        .instruction_enable (instruction_enable),
        .read_enable        (read_enable),
        .write_enable       (write_enable),
        .reg_write          (reg_write),
        .reg_set            (reg_set),
        .jump_pc            (jump_pc),
        .branch_pc          (branch_pc),
        .store_pc           (store_pc)
    );

    nbbpu_regfile u_regfile (
        .clock        (clock),
        .reset        (reset),
        .write_enable (reg_write),
        .write_index  (z_index),     // Results always go to z
        .write_value  (z_value),
        .read_index_a (x_index),
        .read_index_b (y_index),
        .read_value_a (x_value),
        .read_value_b (y_value)
    );

    nbbpu_alu u_alu (
        .x_value     (x_value),
        .y_value     (y_value),
        .instruction (instruction),
        .read_data   (read_data),
        .pc          (pc),
        .result      (z_value)
    );

endmodule

// File: dv/nbbpu_checker.sv
/*
 * Instruction-level model of the core. Steps once per fetch, checks fetch
 * timing, fetch PCs, the RAM enables and every RAM write. A LOAD must read
 * an address that an earlier STORE of the program wrote.
 */
`include "nbbpu_macros.svh"

module nbbpu_checker
(
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    instruction_enable,
    input  logic                    read_enable,
    input  logic                    write_enable,
    input  logic [`NBBPU_WIDTH-1:0] pc,
    input  logic [`NBBPU_WIDTH-1:0] instruction,
    input  logic [`NBBPU_WIDTH-1:0] address,
    input  logic [`NBBPU_WIDTH-1:0] write_data,
    output logic                    done,          // Pass signature seen
    output int                      error_count,
    output int                      check_count
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [15:0] model_regs [16];
    logic [15:0] model_ram [logic [15:0]];
    string       origin [16];      // Opcode that last wrote each register
    string       last_op;
    string       store_name;
    logic [15:0] expected_pc;
    logic [15:0] store_addr;
    logic [15:0] store_data;
    logic        store_due;        // STORE fetched, RAM write still to come
    logic        fetched;
    int          gap;              // Edges since the last fetch

    // ------------------------------------------------------------------------
    // Reference: one instruction on the model state, returns next PC
    // ------------------------------------------------------------------------
    function automatic logic [15:0] execute(
        input  logic [15:0] word,
        input  logic [15:0] at,
        output logic        stores,
        output logic [15:0] st_addr,
        output logic [15:0] st_data
    );
        nbbpu_pkg::opcode_t op;
        logic [3:0]         zi;
        logic [15:0]        xv;
        logic [15:0]        yv;
        logic [15:0]        result;
        logic [15:0]        next;
        logic               writes;

        op = nbbpu_pkg::opcode_t'(word[15:12]);
        zi = word[3:0];
        yv = model_regs[word[7:4]];
        // SETH and CALL name their X register in the z field
        if (op == nbbpu_pkg::OP_SETH || op == nbbpu_pkg::OP_CALL)
            xv = model_regs[zi];
        else
            xv = model_regs[word[11:8]];
        next    = at + 16'd1;
        result  = '0;
        writes  = 1'b1;
        stores  = 1'b0;
        st_addr = xv;
        st_data = yv;
        case (op)
            nbbpu_pkg::OP_ADD:  result = xv + yv;
            nbbpu_pkg::OP_SUB:  result = xv - yv;
            nbbpu_pkg::OP_AND:  result = xv & yv;
            nbbpu_pkg::OP_OR:   result = xv | yv;
            nbbpu_pkg::OP_XOR:  result = xv ^ yv;
            nbbpu_pkg::OP_SHL:  result = xv << yv[3:0];
            nbbpu_pkg::OP_SHR:  result = xv >> yv[3:0];
            nbbpu_pkg::OP_SETL: result = {8'h00, word[11:4]};
            nbbpu_pkg::OP_SETH: result = {word[11:4], xv[7:0]};
            nbbpu_pkg::OP_LOAD:
            begin
                if (model_ram.exists(xv))
                    result = model_ram[xv];
                else
                begin
                    error_count++;
                    $display("LOAD from %h, an address that no STORE has written", xv);
                end
            end
            nbbpu_pkg::OP_STORE:
            begin
                writes = 1'b0;
                stores = 1'b1;
                model_ram[xv] = yv;
            end
            nbbpu_pkg::OP_JUMP:
            begin
                writes = 1'b0;
                next = xv;
            end
            nbbpu_pkg::OP_BRANCH:
            begin
                writes = 1'b0;
                if (yv == 16'h0000)
                    next = xv;   // Taken on Y zero
            end
            nbbpu_pkg::OP_CALL:
            begin
                result = at + 16'd1;   // Link
                next = xv;
            end
            default: writes = 1'b0;
        endcase
        if (writes)
        begin
            model_regs[zi] = result;
            origin[zi] = op.name();
        end
        return next;
    endfunction

    task automatic compare_value(input string test, input logic [15:0] expected,
                                 input logic [15:0] actual);
        if (actual !== expected)
        begin
            error_count++;
            $display("Error %s: expected %h, actual %h", test, expected, actual);
        end
    endtask

    task automatic report_problem(input string text);
        error_count++;
        $display("%s", text);
    endtask

    // ------------------------------------------------------------------------
    // Watchers for the RAM write and the fetch
    // ------------------------------------------------------------------------
    task automatic check_store();
        check_count++;
        if (read_enable)
            report_problem("read_enable was high during a RAM write");
        if (gap != 3)
            report_problem($sformatf("RAM write came %0d cycles after the fetch", gap));
        if (!store_due)
            report_problem($sformatf("RAM write to %h with no STORE in flight", address));
        else
        begin
            compare_value({"address of STORE of ", store_name}, store_addr, address);
            compare_value({"STORE of ", store_name}, store_data, write_data);
        end
        store_due = 1'b0;
        if (address == `NBBPU_PASS_ADDR && write_data == `NBBPU_PASS_DATA)
            done = 1'b1;
    endtask

    task automatic step_fetch();
        nbbpu_pkg::opcode_t op;

        op = nbbpu_pkg::opcode_t'(instruction[15:12]);
        check_count++;
        if (fetched && gap != 4)
            report_problem($sformatf("Fetch came %0d cycles after the previous one", gap));
        if (!fetched && gap != 1)
            report_problem("First fetch did not start right after reset");
        if (store_due)
            report_problem("A STORE instruction never wrote the RAM");
        compare_value({"pc after ", last_op}, expected_pc, pc);
        store_name = origin[instruction[7:4]];
        last_op = op.name();
        expected_pc = execute(instruction, expected_pc, store_due, store_addr, store_data);
        gap = 0;
        fetched = 1'b1;
    endtask

    always @(posedge clock)
    begin
        if (reset)
        begin
            for (int i = 0; i < 16; i++)
            begin
                model_regs[i] = '0;
                origin[i] = "reset value";
            end
            expected_pc = `NBBPU_RESET_PC;
            last_op     = "reset";
            store_due   = 1'b0;
            fetched     = 1'b0;
            gap         = 0;
            done        = 1'b0;
            error_count = 0;
            check_count = 0;
        end
        else
        begin
            gap++;
            if (fetched)   // RAM read only in EXECUTE of a LOAD
                compare_value({"read_enable of ", last_op},
                              16'(gap == 2 && instruction[15:12] == nbbpu_pkg::OP_LOAD),
                              16'(read_enable));
            if (write_enable)
                check_store();
            if (instruction_enable)
                step_fetch();
        end
    end

endmodule

// File: dv/nbbpu_tb.sv
/*
 * Top-level testbench. ROM and RAM are array models that answer
 * combinationally. The program is generated at time zero and must stay
 * under 256 words; it ends with the pass store and a jump to itself.
 */
`include "nbbpu_macros.svh"

module nbbpu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic                    clock;
    logic                    reset;
    logic [`NBBPU_WIDTH-1:0] instruction;
    logic [`NBBPU_WIDTH-1:0] read_data;
    logic                    instruction_enable;
    logic                    read_enable;
    logic                    write_enable;
    logic [`NBBPU_WIDTH-1:0] address;
    logic [`NBBPU_WIDTH-1:0] write_data;
    logic [`NBBPU_WIDTH-1:0] pc;

    logic [`NBBPU_WIDTH-1:0] rom [256];
    logic [`NBBPU_WIDTH-1:0] ram [65536];
    int                      prog_len = 0;
    integer                  seed = 32'hc3e60b90;
    logic                    program_ready = 1'b0;
    logic                    timed_out = 1'b0;
    logic                    done;
    int                      error_count;
    int                      check_count;

    // ------------------------------------------------------------------------
    // Memory models
    // ------------------------------------------------------------------------
    assign instruction = rom[pc[7:0]];
    assign read_data   = ram[address];

    always @(posedge clock)
    begin
        if (write_enable)
            ram[address] <= write_data;
    end

    // ------------------------------------------------------------------------
    // Program generation
    // ------------------------------------------------------------------------
    function automatic logic [15:0] encode(input logic [3:0] op, input logic [3:0] x,
                                           input logic [3:0] y, input logic [3:0] z);
        return {op, x, y, z};
    endfunction

    task automatic emit(input logic [15:0] word);
        rom[prog_len] = word;
        prog_len++;
    endtask

    task automatic set_low(input logic [3:0] r, input logic [7:0] imm);
        emit(encode(nbbpu_pkg::OP_SETL, imm[7:4], imm[3:0], r));
    endtask

    task automatic set_constant(input logic [3:0] r, input logic [15:0] value);
        set_low(r, value[7:0]);
        emit(encode(nbbpu_pkg::OP_SETH, value[15:12], value[11:8], r));
    endtask

    // r3 is the result pointer, r4 holds 1
    task automatic store_and_advance(input logic [3:0] r);
        emit(encode(nbbpu_pkg::OP_STORE, 4'd3, r, 4'd0));
        emit(encode(nbbpu_pkg::OP_ADD, 4'd3, 4'd4, 4'd3));
    endtask

    task automatic build_program();
        logic [31:0] value;

        set_constant(4'd4, 16'd1);
        set_constant(4'd3, 16'h2010);
        for (int round = 0; round < 3; round++)
        begin
            value = $random(seed);
            set_constant(4'd1, value[15:0]);
            set_constant(4'd2, value[31:16]);
            store_and_advance(4'd1);
            store_and_advance(4'd2);
            for (int op = 0; op <= 6; op++)   // ADD through SHR
            begin
                emit(encode(4'(op), 4'd1, 4'd2, 4'd5));
                store_and_advance(4'd5);
            end
        end
        // Read back the last result and store it again
        emit(encode(nbbpu_pkg::OP_SUB, 4'd3, 4'd4, 4'd7));
        emit(encode(nbbpu_pkg::OP_LOAD, 4'd7, 4'd0, 4'd6));
        store_and_advance(4'd6);
        set_low(4'd8, 8'(prog_len + 3));
        emit(encode(nbbpu_pkg::OP_JUMP, 4'd8, 4'd0, 4'd0));
        emit(encode(nbbpu_pkg::OP_NOP, 4'd0, 4'd0, 4'd0));      // Skipped
        set_low(4'd8, 8'(prog_len + 3));
        emit(encode(nbbpu_pkg::OP_BRANCH, 4'd8, 4'd0, 4'd0));   // r0 zero, taken
        emit(encode(nbbpu_pkg::OP_NOP, 4'd0, 4'd0, 4'd0));
        set_low(4'd8, 8'(prog_len + 3));
        emit(encode(nbbpu_pkg::OP_BRANCH, 4'd8, 4'd4, 4'd0));   // Not taken
        store_and_advance(4'd4);
        set_low(4'd9, 8'(prog_len + 3));
        emit(encode(nbbpu_pkg::OP_CALL, 4'd0, 4'd0, 4'd9));
        emit(encode(nbbpu_pkg::OP_NOP, 4'd0, 4'd0, 4'd0));
        store_and_advance(4'd9);                                 // Saved link
        set_constant(4'd10, `NBBPU_PASS_DATA);
        set_constant(4'd11, `NBBPU_PASS_ADDR);
        emit(encode(nbbpu_pkg::OP_STORE, 4'd11, 4'd10, 4'd0));
        set_low(4'd12, 8'(prog_len + 1));
        emit(encode(nbbpu_pkg::OP_JUMP, 4'd12, 4'd0, 4'd0));   // Parks here
    endtask

    // ------------------------------------------------------------------------
    // Clock, reset, watchdog and verdict
    // ------------------------------------------------------------------------
    initial
    begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Twice the program at four cycles of 10 ns, plus reset
    initial
    begin
        wait (program_ready);
        #((2 * prog_len * 4 + 5) * 10);
        timed_out = 1'b1;
    end

    initial
    begin
        reset = 1'b1;
        build_program();
        program_ready = 1'b1;
        repeat (5) @(posedge clock);
        reset <= 1'b0;
        wait (done || timed_out);
        if (!done)
            $display("Watchdog expired before the program reached the pass store");
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (done && error_count == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

    nbbpu_core DUT (
        .clock              (clock),
        .reset              (reset),
        .instruction        (instruction),
        .read_data          (read_data),
        .instruction_enable (instruction_enable),
        .read_enable        (read_enable),
        .write_enable       (write_enable),
        .address            (address),
        .write_data         (write_data),
        .pc                 (pc)
    );

    nbbpu_checker u_checker (
        .clock              (clock),
        .reset              (reset),
        .instruction_enable (instruction_enable),
        .read_enable        (read_enable),
        .write_enable       (write_enable),
        .pc                 (pc),
        .instruction        (instruction),
        .address            (address),
        .write_data         (write_data),
        .done               (done),
        .error_count        (error_count),
        .check_count        (check_count)
    );

endmodule

// File: all.f
+incdir+hw
hw/nbbpu_pkg.sv
hw/nbbpu_controller.sv
hw/nbbpu_regfile.sv
hw/nbbpu_alu.sv
hw/nbbpu_core.sv
dv/nbbpu_checker.sv
dv/nbbpu_tb.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP      := nbbpu_tb
FILELIST := all.f
BUILD    := obj_dir
LOG      := sim.log
PASS     := Test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS)" $(LOG) || (echo "Simulation did not pass, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
